//--- design/conv_pkg.sv
`default_nettype none

package conv_pkg;

	// pixel and weight width
	localparam int PIX_W = 8;

	// pixels per row word, also the lane count
	localparam int LANES = 8;

	localparam int ROW_W = LANES * PIX_W;	// one row word
	localparam int ROWS = 3;	// window height
	localparam int TAPS = 9;	// 3x3 kernel
	localparam int PROD_W = 16;	// full 8x8 product

	localparam int LANE_W = TAPS * PROD_W;	// nine products per lane
	localparam int RES_W = LANES * LANE_W;

	// weight words to cover the kernel
	localparam int WORDS = 2;

	// level-coded control input
	typedef enum logic [1:0] {
		CTRL_END = 2'd0,
		CTRL_START = 2'd1,
		CTRL_HOLD = 2'd2,
		CTRL_IDLE = 2'd3	// no-op code
	} ctrl_e;

	typedef enum logic [1:0] {
		ST_WAIT = 2'd0,
		ST_COMPUTE = 2'd1,
		ST_FINISH = 2'd2
	} state_e;

endpackage

`default_nettype wire

//--- design/conv_ctrl.sv
`default_nettype none

module conv_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire conv_pkg::ctrl_e i_ctrl,
	output logic o_res_valid,
	output logic o_finish,
	output logic o_release
);

	conv_pkg::state_e state_q;
	conv_pkg::state_e state_d;
	logic res_valid_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			conv_pkg::ST_WAIT: begin
				case (i_ctrl)
					conv_pkg::CTRL_START: state_d = conv_pkg::ST_COMPUTE;
					conv_pkg::CTRL_END: state_d = conv_pkg::ST_FINISH;
					conv_pkg::CTRL_HOLD, conv_pkg::CTRL_IDLE: state_d = conv_pkg::ST_WAIT;
					default: state_d = state_q;
				endcase
			end
			conv_pkg::ST_COMPUTE: begin
				if (i_ctrl == conv_pkg::CTRL_HOLD) begin
					state_d = conv_pkg::ST_WAIT;
				end else if (i_ctrl == conv_pkg::CTRL_END) begin
					state_d = conv_pkg::ST_FINISH;
				end
			end
			conv_pkg::ST_FINISH: state_d = conv_pkg::ST_FINISH;	// only reset leaves
			default: state_d = conv_pkg::ST_WAIT;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= conv_pkg::ST_WAIT;
			res_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			res_valid_q <= (state_q == conv_pkg::ST_COMPUTE);	// lines up with cube stage
		end
	end

	assign o_res_valid = res_valid_q;
	assign o_finish = (state_q == conv_pkg::ST_FINISH);

	// hold out of compute drops the loaded kernel
	assign o_release = (state_q == conv_pkg::ST_COMPUTE) && (i_ctrl == conv_pkg::CTRL_HOLD);

	a_finish_sticky: assert property (
		@(posedge clk) disable iff (!rst)
		(state_q == conv_pkg::ST_FINISH) |=> (state_q == conv_pkg::ST_FINISH)
	);

endmodule

`default_nettype wire

//--- design/row_window.sv
`default_nettype none

module row_window (
	input wire logic clk,
	input wire logic rst,
	input wire logic i_valid,
	input wire logic [conv_pkg::ROW_W-1:0] i_data,
	output logic [conv_pkg::ROW_W-1:0] o_row0,
	output logic [conv_pkg::ROW_W-1:0] o_row1,
	output logic [conv_pkg::ROW_W-1:0] o_row2
);

	logic [conv_pkg::ROW_W-1:0] row0_q;	// oldest
	logic [conv_pkg::ROW_W-1:0] row1_q;
	logic [conv_pkg::ROW_W-1:0] row2_q;	// newest

	// steps in any state, the controller does not gate it
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row0_q <= '0;
			row1_q <= '0;
			row2_q <= '0;
		end else if (i_valid) begin
			row0_q <= row1_q;
			row1_q <= row2_q;
			row2_q <= i_data;
		end
	end

	assign o_row0 = row0_q;
	assign o_row1 = row1_q;
	assign o_row2 = row2_q;

endmodule

`default_nettype wire

//--- design/weight_buf.sv
`default_nettype none

module weight_buf (
	input wire logic clk,
	input wire logic rst,
	input wire logic i_w_valid,
	input wire logic [conv_pkg::ROW_W-1:0] i_w_data,
	input wire logic i_release,
	output logic [conv_pkg::TAPS*conv_pkg::PIX_W-1:0] o_kernel
);

	localparam int CNT_W = $clog2(conv_pkg::WORDS + 1);
	localparam int BUF_W = conv_pkg::WORDS * conv_pkg::ROW_W;

	logic [BUF_W-1:0] words_q;	// word 0 in the low bits
	logic [CNT_W-1:0] w_cnt;
	logic buf_full;

	assign buf_full = (w_cnt == CNT_W'(conv_pkg::WORDS));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			words_q <= '0;
			w_cnt <= '0;
		end else if (i_release) begin
			words_q <= '0;	// release beats a same-cycle write
			w_cnt <= '0;
		end else if (i_w_valid && !buf_full) begin
			words_q[w_cnt*conv_pkg::ROW_W +: conv_pkg::ROW_W] <= i_w_data;
			w_cnt <= w_cnt + 1'b1;
		end
	end

	// taps 0-7 from word 0, tap 8 from byte 0 of word 1
	assign o_kernel = words_q[conv_pkg::TAPS*conv_pkg::PIX_W-1:0];

	a_no_overfill: assert property (
		@(posedge clk) disable iff (!rst)
		i_w_valid |-> !buf_full
	);

endmodule

`default_nettype wire

//--- design/tap_cube.sv
`default_nettype none

module tap_cube #(
	parameter int LANE = 0	// first window column
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [conv_pkg::ROW_W-1:0] i_row0,
	input wire logic [conv_pkg::ROW_W-1:0] i_row1,
	input wire logic [conv_pkg::ROW_W-1:0] i_row2,
	input wire logic [conv_pkg::TAPS*conv_pkg::PIX_W-1:0] i_kernel,
	output logic [conv_pkg::LANE_W-1:0] o_products
);

	localparam int COLS = conv_pkg::TAPS / conv_pkg::ROWS;
	localparam int PW = conv_pkg::PIX_W;

	logic [conv_pkg::ROW_W-1:0] rows_q [conv_pkg::ROWS];
	logic [conv_pkg::TAPS*PW-1:0] kernel_q;
	logic [conv_pkg::TAPS*PW-1:0] window;

	if (LANE < 0 || LANE >= conv_pkg::LANES) begin : g_bad_lane
		$error("tap_cube: LANE %0d outside 0..%0d", LANE, conv_pkg::LANES - 1);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rows_q[0] <= '0;
			rows_q[1] <= '0;
			rows_q[2] <= '0;
			kernel_q <= '0;
		end else begin
			rows_q[0] <= i_row0;
			rows_q[1] <= i_row1;
			rows_q[2] <= i_row2;
			kernel_q <= i_kernel;
		end
	end

	// right edge lanes wrap back to column 0
	always_comb begin
		window = '0;
		for (int r = 0; r < conv_pkg::ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				window[(r*COLS+c)*PW +: PW] =
					rows_q[r][((LANE + c) % conv_pkg::LANES)*PW +: PW];
			end
		end
	end

	for (genvar t = 0; t < conv_pkg::TAPS; t++) begin : g_tap
		assign o_products[t*conv_pkg::PROD_W +: conv_pkg::PROD_W] =
			conv_pkg::PROD_W'(kernel_q[t*PW +: PW]) *
			conv_pkg::PROD_W'(window[t*PW +: PW]);	// unsigned
	end

endmodule

`default_nettype wire

//--- design/conv_core.sv
`default_nettype none

module conv_core #(
	parameter int N_LANES = conv_pkg::LANES
) (
	input wire logic clk,
	input wire logic rst,
	input wire conv_pkg::ctrl_e i_ctrl,
	input wire logic [conv_pkg::ROW_W-1:0] i_data,
	input wire logic i_valid,
	input wire logic [conv_pkg::ROW_W-1:0] i_w_data,
	input wire logic i_w_valid,
	output logic [conv_pkg::RES_W-1:0] o_result,
	output logic o_res_valid,
	output logic o_finish
);

	logic release_pulse;
	logic [conv_pkg::ROW_W-1:0] row0;
	logic [conv_pkg::ROW_W-1:0] row1;
	logic [conv_pkg::ROW_W-1:0] row2;
	logic [conv_pkg::TAPS*conv_pkg::PIX_W-1:0] kernel;

	// the result bus has one slice per lane
	if (N_LANES != conv_pkg::LANES) begin : g_bad_lanes
		$error("conv_core: N_LANES %0d must equal %0d", N_LANES, conv_pkg::LANES);
	end

	conv_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.i_ctrl(i_ctrl),
		.o_res_valid(o_res_valid),
		.o_finish(o_finish),
		.o_release(release_pulse)
	);

	row_window u_rows (
		.clk(clk),
		.rst(rst),
		.i_valid(i_valid),
		.i_data(i_data),
		.o_row0(row0),
		.o_row1(row1),
		.o_row2(row2)
	);

	weight_buf u_weights (
		.clk(clk),
		.rst(rst),
		.i_w_valid(i_w_valid),
		.i_w_data(i_w_data),
		.i_release(release_pulse),
		.o_kernel(kernel)
	);

	for (genvar k = 0; k < N_LANES; k++) begin : g_lane
		tap_cube #(
			.LANE(k)
		) u_cube (
			.clk(clk),
			.rst(rst),
			.i_row0(row0),
			.i_row1(row1),
			.i_row2(row2),
			.i_kernel(kernel),
			.o_products(o_result[k*conv_pkg::LANE_W +: conv_pkg::LANE_W])	// lane k at slice k
		);
	end

endmodule

`default_nettype wire

//--- test/conv_core_tb.sv
`default_nettype none

module conv_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RST_CYC = 8;
	localparam int RAND_CYC = 24;
	localparam int TEST_CYCLES = RST_CYC + 2 * RAND_CYC + 48;
	localparam int RW = conv_pkg::ROW_W;
	localparam int KW = conv_pkg::TAPS * conv_pkg::PIX_W;
	localparam int LW = conv_pkg::LANE_W;

	logic clk;
	logic rst;
	conv_pkg::ctrl_e ctrl;
	logic [RW-1:0] data;
	logic valid;
	logic [RW-1:0] w_data;
	logic w_valid;
	logic [conv_pkg::RES_W-1:0] result;
	logic res_valid;
	logic finish;

	int errors = 0;
	logic [31:0] lcg_state = 32'hcce5;

	// reference copies of the DUT registers, built from the driven inputs
	logic [RW-1:0] m_row0, m_row1, m_row2;
	logic [RW-1:0] m_words [conv_pkg::WORDS];
	int m_wcnt;
	conv_pkg::state_e m_state;
	logic [RW-1:0] c_row0, c_row1, c_row2;	// one stage later, like the lanes
	logic [KW-1:0] c_kern;
	logic exp_valid;
	logic exp_finish;
	logic hold_q1, hold_q2;
	logic [conv_pkg::RES_W-1:0] exp_result;

	conv_core #(
		.N_LANES(conv_pkg::LANES)
	) dut (
		.clk(clk),
		.rst(rst),
		.i_ctrl(ctrl),
		.i_data(data),
		.i_valid(valid),
		.i_w_data(w_data),
		.i_w_valid(w_valid),
		.o_result(result),
		.o_res_valid(res_valid),
		.o_finish(finish)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [RW-1:0] random_row();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_random();
		lo = next_random();
		return {hi, lo};
	endfunction

	// byte j of row r reads as r+1 in the high nibble and j in the low one
	function automatic logic [RW-1:0] pattern_row(input int r);
		logic [RW-1:0] w;
		for (int j = 0; j < conv_pkg::LANES; j++) begin
			w[j*8 +: 8] = 8'((r + 1) * 16 + j);
		end
		return w;
	endfunction

	function automatic conv_pkg::state_e step_state(input conv_pkg::state_e s,
			input conv_pkg::ctrl_e c);
		case (s)
			conv_pkg::ST_WAIT: begin
				if (c == conv_pkg::CTRL_START) return conv_pkg::ST_COMPUTE;
				if (c == conv_pkg::CTRL_END) return conv_pkg::ST_FINISH;
			end
			conv_pkg::ST_COMPUTE: begin
				if (c == conv_pkg::CTRL_HOLD) return conv_pkg::ST_WAIT;
				if (c == conv_pkg::CTRL_END) return conv_pkg::ST_FINISH;
			end
			default: return s;
		endcase
		return s;
	endfunction

	// tap t = 3r + c, lane k reads column (k + c) mod LANES
	function automatic logic [conv_pkg::RES_W-1:0] conv_model(input logic [RW-1:0] r0,
			input logic [RW-1:0] r1, input logic [RW-1:0] r2, input logic [KW-1:0] kern);
		logic [conv_pkg::RES_W-1:0] res;
		logic [RW-1:0] rows [3];
		logic [7:0] pix;
		logic [7:0] w;
		int t;
		rows[0] = r0;
		rows[1] = r1;
		rows[2] = r2;
		res = '0;
		for (int k = 0; k < conv_pkg::LANES; k++) begin
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					t = 3 * r + c;
					pix = rows[r][((k + c) % conv_pkg::LANES) * 8 +: 8];
					w = kern[t*8 +: 8];
					res[k*LW + t*conv_pkg::PROD_W +: conv_pkg::PROD_W] = 16'(pix) * 16'(w);
				end
			end
		end
		return res;
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			m_row0 <= '0;
			m_row1 <= '0;
			m_row2 <= '0;
			m_words[0] <= '0;
			m_words[1] <= '0;
			m_wcnt <= 0;
			m_state <= conv_pkg::ST_WAIT;
			c_row0 <= '0;
			c_row1 <= '0;
			c_row2 <= '0;
			c_kern <= '0;
			exp_valid <= 1'b0;
			hold_q1 <= 1'b0;
			hold_q2 <= 1'b0;
		end else begin
			if (valid) begin
				m_row0 <= m_row1;
				m_row1 <= m_row2;
				m_row2 <= data;
			end
			if (m_state == conv_pkg::ST_COMPUTE && ctrl == conv_pkg::CTRL_HOLD) begin
				m_words[0] <= '0;	// kernel dropped on release
				m_words[1] <= '0;
				m_wcnt <= 0;
			end else if (w_valid && m_wcnt < conv_pkg::WORDS) begin
				m_words[m_wcnt] <= w_data;
				m_wcnt <= m_wcnt + 1;
			end
			m_state <= step_state(m_state, ctrl);
			exp_valid <= (m_state == conv_pkg::ST_COMPUTE);
			c_row0 <= m_row0;
			c_row1 <= m_row1;
			c_row2 <= m_row2;
			c_kern <= {m_words[1][7:0], m_words[0]};
			hold_q1 <= (m_state == conv_pkg::ST_COMPUTE && ctrl == conv_pkg::CTRL_HOLD);
			hold_q2 <= hold_q1;
		end
	end

	always_comb exp_result = conv_model(c_row0, c_row1, c_row2, c_kern);
	assign exp_finish = (m_state == conv_pkg::ST_FINISH);

	a_reset_quiet: assert property (@(posedge clk)
		!rst |-> (result == '0 && !res_valid && !finish))
	else begin
		errors++;
		$display("error at %0t: outputs in reset expected zero got result %h valid %b finish %b",
			$time, $sampled(result), $sampled(res_valid), $sampled(finish));
	end

	for (genvar k = 0; k < conv_pkg::LANES; k++) begin : g_lane_chk
		a_lane: assert property (@(posedge clk) disable iff (!rst)
			result[k*LW +: LW] == exp_result[k*LW +: LW])
		else begin
			errors++;
			$display("error at %0t: o_result lane %0d expected %h got %h", $time, k,
				$sampled(exp_result[k*LW +: LW]), $sampled(result[k*LW +: LW]));
		end
	end

	a_res_valid: assert property (@(posedge clk) disable iff (!rst) res_valid == exp_valid)
	else begin
		errors++;
		$display("error at %0t: o_res_valid expected %b got %b", $time,
			$sampled(exp_valid), $sampled(res_valid));
	end

	a_finish: assert property (@(posedge clk) disable iff (!rst) finish == exp_finish)
	else begin
		errors++;
		$display("error at %0t: o_finish expected %b got %b", $time,
			$sampled(exp_finish), $sampled(finish));
	end

	// two cycles after a release the whole bus reads zero
	a_hold_clear: assert property (@(posedge clk) disable iff (!rst) hold_q2 |-> result == '0)
	else begin
		errors++;
		$display("error at %0t: o_result after release expected 0 got %h", $time,
			$sampled(result));
	end

	task automatic apply_cycle(input conv_pkg::ctrl_e c, input logic v, input logic [RW-1:0] d,
			input logic wv, input logic [RW-1:0] wd);
		@(negedge clk);
		ctrl = c;
		valid = v;
		data = d;
		w_valid = wv;
		w_data = wd;
	endtask

	task automatic random_cycle(input conv_pkg::ctrl_e c);
		logic [31:0] pick;
		pick = next_random();
		apply_cycle(c, pick[9], random_row(), 1'b0, '0);
	endtask

	task automatic load_weights();
		apply_cycle(conv_pkg::CTRL_IDLE, 1'b0, '0, 1'b1, random_row());
		apply_cycle(conv_pkg::CTRL_IDLE, 1'b0, '0, 1'b1, random_row());
	endtask

	task automatic compute_phase();
		logic [31:0] pick;
		apply_cycle(conv_pkg::CTRL_START, 1'b1, random_row(), 1'b0, '0);
		for (int i = 0; i < RAND_CYC; i++) begin
			pick = next_random();
			random_cycle(pick[13] ? conv_pkg::CTRL_START : conv_pkg::CTRL_IDLE);
		end
	endtask

	initial begin
		rst = 1'b0;
		ctrl = conv_pkg::CTRL_IDLE;
		valid = 1'b0;
		data = '0;
		w_valid = 1'b0;
		w_data = '0;
		repeat (RST_CYC) @(negedge clk);
		rst = 1'b1;
		repeat (3) apply_cycle(conv_pkg::CTRL_IDLE, 1'b0, '0, 1'b0, '0);
		load_weights();
		repeat (6) random_cycle(conv_pkg::CTRL_IDLE);	// rows stream in WAIT too
		compute_phase();
		for (int r = 0; r < 3; r++) begin
			apply_cycle(conv_pkg::CTRL_IDLE, 1'b1, pattern_row(r), 1'b0, '0);	// wrap lanes
		end
		repeat (2) apply_cycle(conv_pkg::CTRL_IDLE, 1'b0, '0, 1'b0, '0);
		apply_cycle(conv_pkg::CTRL_HOLD, 1'b0, '0, 1'b0, '0);
		repeat (4) random_cycle(conv_pkg::CTRL_IDLE);
		load_weights();
		compute_phase();
		apply_cycle(conv_pkg::CTRL_HOLD, 1'b1, random_row(), 1'b0, '0);
		repeat (3) random_cycle(conv_pkg::CTRL_IDLE);
		apply_cycle(conv_pkg::CTRL_HOLD, 1'b0, '0, 1'b0, '0);	// no effect in WAIT
		apply_cycle(conv_pkg::CTRL_END, 1'b0, '0, 1'b0, '0);
		repeat (3) random_cycle(conv_pkg::CTRL_START);	// stays in FINISH
		repeat (3) apply_cycle(conv_pkg::CTRL_IDLE, 1'b0, '0, 1'b0, '0);
		$display("checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#((TEST_CYCLES + 50) * 100);
		$display("watchdog expired before the stimulus completed, %0d errors", errors);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
design/conv_pkg.sv
design/conv_ctrl.sv
design/row_window.sv
design/weight_buf.sv
design/tap_cube.sv
design/conv_core.sv
test/conv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the conv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module conv_core_tb -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vconv_core_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi

echo "pass message not found"
exit 1
